/* tlb.f */
src/tlb_pkg.sv
src/tlb_entry_store.sv
src/tlb_lookup.sv
src/tlb.sv
dv/tlb_assertions.sv
dv/tb_tlb.sv

/* Makefile */
SRCS := $(shell cat tlb.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_tlb: tlb.f $(SRCS)
	verilator --binary --assert --top-module tb_tlb -f tlb.f

run: obj_dir/Vtb_tlb
	./obj_dir/Vtb_tlb > sim.log 2>&1 || (cat sim.log; false)
	cat sim.log
	! grep -q "sim failed" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/tb_tlb.sv */
`timescale 1ns/10ps

module tb_tlb;

    localparam int tlb_num = tlb_pkg::TLBNUM_DEFAULT;
    localparam int idx_w = (tlb_num > 1) ? $clog2(tlb_num) : 1;
    // about four times the length of all tests
    localparam int max_cycles = 2000;

    logic                 clk;
    logic                 we;
    tlb_pkg::tlb_search_t s0_req;
    logic                 s0_found;
    logic [idx_w-1:0]     s0_index;
    tlb_pkg::tlb_page_t   s0_page;
    tlb_pkg::tlb_search_t s1_req;
    logic                 s1_found;
    logic [idx_w-1:0]     s1_index;
    tlb_pkg::tlb_page_t   s1_page;
    logic                 w_valid;
    logic [idx_w-1:0]     w_index;
    tlb_pkg::tlb_entry_t  w_entry;
    logic [idx_w-1:0]     r_index;
    tlb_pkg::tlb_entry_t  r_entry;

    // mirror of the dut entries, updated at the write edge
    tlb_pkg::tlb_entry_t model [tlb_num];

    integer seed;
    int     errors = 0;
    int     test_start = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     cycles = 0;

    tlb dut (
        .clk      (clk),
        .we       (we),
        .s0_req   (s0_req),
        .s0_found (s0_found),
        .s0_index (s0_index),
        .s0_page  (s0_page),
        .s1_req   (s1_req),
        .s1_found (s1_found),
        .s1_index (s1_index),
        .s1_page  (s1_page),
        .w_valid  (w_valid),
        .w_index  (w_index),
        .w_entry  (w_entry),
        .r_index  (r_index),
        .r_entry  (r_entry)
    );

    bind tlb tlb_assertions #(.tlb_num(tlb_num)) u_assertions (
        .clk(clk), .we(we),
        .s0_req(s0_req), .s0_found(s0_found), .s0_index(s0_index), .s0_page(s0_page),
        .s1_req(s1_req), .s1_found(s1_found), .s1_index(s1_index), .s1_page(s1_page),
        .r_entry(r_entry), .entries(entries)
    );

    // 8 ns period
    always #4 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("sim failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // first match wins, entries are unique anyway
    task automatic model_search(input tlb_pkg::tlb_search_t req, output logic f,
                                output logic [idx_w-1:0] idx, output tlb_pkg::tlb_page_t pg);
        f = 1'b0;
        idx = '0;
        pg = '0;
        for (int i = 0; i < tlb_num; i++) begin
            if (!f && model[i].vpn2 == req.vpn2 && (model[i].g || model[i].asid == req.asid)) begin
                f = 1'b1;
                idx = idx_w'(i);
                pg = req.odd_page ? model[i].page1 : model[i].page0;
            end
        end
    endtask

    task automatic check_port(input int port, input tlb_pkg::tlb_search_t req, input logic f_act,
                              input logic [idx_w-1:0] i_act, input tlb_pkg::tlb_page_t p_act);
        logic                f_exp;
        logic [idx_w-1:0]    i_exp;
        tlb_pkg::tlb_page_t  p_exp;
        model_search(req, f_exp, i_exp, p_exp);
        assert (f_act == f_exp) else begin
            $display("Mismatch s%0d_found: expected %h, got %h", port, f_exp, f_act);
            errors++;
        end
        assert (i_act == i_exp) else begin
            $display("Mismatch s%0d_index: expected %h, got %h", port, i_exp, i_act);
            errors++;
        end
        assert (p_act == p_exp) else begin
            $display("Mismatch s%0d_page: expected %h, got %h", port, p_exp, p_act);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    // one cycle: drive at the falling edge, check, then let the edge take the write
    task automatic step(input logic wv, input logic [idx_w-1:0] widx,
                        input tlb_pkg::tlb_entry_t went, input tlb_pkg::tlb_search_t q0,
                        input tlb_pkg::tlb_search_t q1, input logic [idx_w-1:0] ridx);
        @(negedge clk);
        w_valid = wv;
        w_index = widx;
        w_entry = went;
        s0_req = q0;
        s1_req = q1;
        r_index = ridx;
        // combinational outputs settled long before the rising edge
        #2;
        check_port(0, q0, s0_found, s0_index, s0_page);
        check_port(1, q1, s1_found, s1_index, s1_page);
        assert (r_entry == model[ridx]) else begin
            $display("Mismatch r_entry: expected %h, got %h", model[ridx], r_entry);
            errors++;
        end
        @(posedge clk);
        if (wv) begin
            model[widx] = went;
        end
    endtask

    task automatic search(input tlb_pkg::tlb_search_t q0, input tlb_pkg::tlb_search_t q1,
                          input logic [idx_w-1:0] ridx);
        step(1'b0, '0, '0, q0, q1, ridx);
    endtask

    // both ports look for the entry being written
    // it only shows up after the edge
    task automatic write(input logic [idx_w-1:0] widx, input tlb_pkg::tlb_entry_t went);
        step(1'b1, widx, went, make_req(went.vpn2, 1'b0, went.asid),
             make_req(went.vpn2, 1'b1, went.asid), widx);
    endtask

    function automatic tlb_pkg::tlb_search_t make_req(input tlb_pkg::vpn2_t vpn2,
                                                      input logic odd, input tlb_pkg::asid_t asid);
        tlb_pkg::tlb_search_t q;
        q.vpn2 = vpn2;
        q.odd_page = odd;
        q.asid = asid;
        return q;
    endfunction

    function automatic tlb_pkg::tlb_page_t random_page();
        logic [31:0] r;
        r = $random(seed);
        return r[24:0];
    endfunction

    // low vpn2 bits carry the index, so no two entries share a vpn2
    function automatic tlb_pkg::tlb_entry_t random_entry(input int idx, input logic g);
        logic [31:0]         r;
        tlb_pkg::tlb_entry_t e;
        r = $random(seed);
        e.vpn2 = {1'b1, r[17-idx_w:0], idx_w'(idx)};
        e.asid = r[31:24];
        e.g = g;
        e.page0 = random_page();
        e.page1 = random_page();
        return e;
    endfunction

    task automatic end_test(input int num, input string name);
        if (errors == test_start) begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, errors - test_start);
        end
        test_start = errors;
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    initial begin
        tlb_pkg::tlb_entry_t e;
        tlb_pkg::tlb_entry_t old_e;
        logic [31:0]         r;
        int                  a;
        int                  b;
        seed = 80;
        clk = 1'b0;
        we = 1'b1;
        s0_req = '0;
        s1_req = '0;
        w_valid = 1'b0;
        w_index = '0;
        w_entry = '0;
        r_index = '0;
        for (int i = 0; i < tlb_num; i++) begin
            model[i] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        we = 1'b0;

        // reset state, nonzero vpn2 misses
        for (int i = 0; i < tlb_num; i++) begin
            r = $random(seed);
            search(make_req({1'b1, r[17:0]}, r[18], r[26:19]),
                   make_req({r[17:0], 1'b1}, r[19], r[31:24]), idx_w'(i));
        end
        end_test(1, "reset state");

        // fill every index, then hit with own asid and miss with another
        for (int i = 0; i < tlb_num; i++) begin
            e = random_entry(i, 1'b0);
            write(idx_w'(i), e);
        end
        for (int i = 0; i < tlb_num; i++) begin
            r = $random(seed);
            search(make_req(model[i].vpn2, r[0], model[i].asid),
                   make_req(model[i].vpn2, r[1], model[i].asid ^ 8'h5a), idx_w'(i));
        end
        end_test(2, "write and search");

        // global entry ignores asid
        e = random_entry(3, 1'b1);
        write(idx_w'(3), e);
        repeat (8) begin
            r = $random(seed);
            search(make_req(e.vpn2, r[0], r[15:8]), make_req(e.vpn2, r[1], r[23:16]), idx_w'(3));
        end
        end_test(3, "global entry");

        // two ports, two different entries in one cycle
        repeat (16) begin
            r = $random(seed);
            a = int'(r[idx_w-1:0]);
            b = (a + 1 + int'(r[11:8]) % (tlb_num - 1)) % tlb_num;
            search(make_req(model[a].vpn2, r[12], model[a].asid),
                   make_req(model[b].vpn2, r[13], model[b].asid), idx_w'(a));
        end
        end_test(4, "dual port");

        // overwrite, old vpn2 gone, new one visible after the edge
        old_e = model[7];
        e = random_entry(7, 1'b0);
        e.vpn2 = old_e.vpn2 ^ 19'h20000;
        write(idx_w'(7), e);
        search(make_req(old_e.vpn2, 1'b0, old_e.asid), make_req(e.vpn2, 1'b1, e.asid), idx_w'(7));
        search(make_req(e.vpn2, 1'b0, e.asid), make_req(old_e.vpn2, 1'b1, old_e.asid), idx_w'(7));
        end_test(5, "overwrite");

        // random mix, writes keep the index in the low vpn2 bits
        repeat (400) begin
            r = $random(seed);
            a = int'(r[10:7]) % tlb_num;
            b = int'(r[24:21]) % tlb_num;
            e = random_entry(int'(r[4:1]) % tlb_num, r[5] & r[6]);
            step(r[0], idx_w'(int'(r[4:1]) % tlb_num), e,
                 make_req(model[a].vpn2, r[11], r[20] ? model[a].asid : r[19:12]),
                 make_req(r[25] ? model[b].vpn2 : {r[31:26], r[12:0]}, r[26], model[b].asid),
                 idx_w'(b));
        end
        end_test(6, "random mix");

        $display("tests: %0d passed, %0d failed, %0d check errors, %0d assertion failures",
                 tests_passed, tests_failed, errors, dut.u_assertions.fail_count);
        if (tests_failed == 0 && dut.u_assertions.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* dv/tlb_assertions.sv */
`timescale 1ns/10ps

module tlb_assertions #(
    parameter int tlb_num = tlb_pkg::TLBNUM_DEFAULT,
    localparam int idx_w = (tlb_num > 1) ? $clog2(tlb_num) : 1
) (
    input logic                              clk,
    input logic                              we,
    // search port 0
    input tlb_pkg::tlb_search_t              s0_req,
    input logic                              s0_found,
    input logic [idx_w-1:0]                  s0_index,
    input tlb_pkg::tlb_page_t                s0_page,
    // search port 1
    input tlb_pkg::tlb_search_t              s1_req,
    input logic                              s1_found,
    input logic [idx_w-1:0]                  s1_index,
    input tlb_pkg::tlb_page_t                s1_page,
    // read port and the stored array
    input tlb_pkg::tlb_entry_t               r_entry,
    input tlb_pkg::tlb_entry_t [tlb_num-1:0] entries
);

    // failed checks so far
    int fail_count = 0;

    ////////////////////////////////////////
    // miss gives a clean result
    ////////////////////////////////////////

    // index and page both zero on a miss
    a_s0_miss_zero: assert property (
        @(posedge clk) disable iff (we)
        !s0_found |-> (s0_index == '0 && s0_page == '0)
    ) else begin
        $error("port 0 miss with nonzero index or page");
        fail_count++;
    end

    a_s1_miss_zero: assert property (
        @(posedge clk) disable iff (we)
        !s1_found |-> (s1_index == '0 && s1_page == '0)
    ) else begin
        $error("port 1 miss with nonzero index or page");
        fail_count++;
    end

    ////////////////////////////////////////
    // reset state
    ////////////////////////////////////////

    // cleared array reads zero at any index
    a_reset_read_zero: assert property (
        @(posedge clk)
        we |-> r_entry == '0
    ) else begin
        $error("read port not zero during reset");
        fail_count++;
    end

    ////////////////////////////////////////
    // hit points at a matching entry
    ////////////////////////////////////////

    // reported index holds the requested vpn2
    a_s0_hit_vpn2: assert property (
        @(posedge clk) disable iff (we)
        s0_found |-> entries[s0_index].vpn2 == s0_req.vpn2
    ) else begin
        $error("port 0 hit index holds another vpn2");
        fail_count++;
    end

    a_s1_hit_vpn2: assert property (
        @(posedge clk) disable iff (we)
        s1_found |-> entries[s1_index].vpn2 == s1_req.vpn2
    ) else begin
        $error("port 1 hit index holds another vpn2");
        fail_count++;
    end

endmodule

/* src/tlb.sv */
`timescale 1ns/10ps

module tlb #(
    parameter int tlb_num = tlb_pkg::TLBNUM_DEFAULT
) (
    input  logic                 clk,
    // asynchronous reset, clears all entries
    input  logic                 we,
    // search port 0
    input  tlb_pkg::tlb_search_t s0_req,
    output logic                 s0_found,
    output logic [idx_w-1:0]     s0_index,
    output tlb_pkg::tlb_page_t   s0_page,
    // search port 1
    input  tlb_pkg::tlb_search_t s1_req,
    output logic                 s1_found,
    output logic [idx_w-1:0]     s1_index,
    output tlb_pkg::tlb_page_t   s1_page,
    // write port, always accepted
    input  logic                 w_valid,
    input  logic [idx_w-1:0]     w_index,
    input  tlb_pkg::tlb_entry_t  w_entry,
    // read port
    input  logic [idx_w-1:0]     r_index,
    output tlb_pkg::tlb_entry_t  r_entry
);

    // index width for the port vectors
    localparam int idx_w = (tlb_num > 1) ? $clog2(tlb_num) : 1;

    // shared entry array
    tlb_pkg::tlb_entry_t [tlb_num-1:0] entries;

    ////////////////////////////////////////
    // entry store
    ////////////////////////////////////////

    tlb_entry_store #(
        .tlb_num (tlb_num)
    ) u_store (
        .clk     (clk),
        .we      (we),
        .w_valid (w_valid),
        .w_index (w_index),
        .w_entry (w_entry),
        .r_index (r_index),
        .r_entry (r_entry),
        .entries (entries)
    );

    ////////////////////////////////////////
    // search ports
    ////////////////////////////////////////

    // port 0, usually instruction fetch
    tlb_lookup #(
        .tlb_num (tlb_num)
    ) u_lookup0 (
        .entries (entries),
        .req     (s0_req),
        .found   (s0_found),
        .index   (s0_index),
        .page    (s0_page)
    );

    // port 1, usually data access
    tlb_lookup #(
        .tlb_num (tlb_num)
    ) u_lookup1 (
        .entries (entries),
        .req     (s1_req),
        .found   (s1_found),
        .index   (s1_index),
        .page    (s1_page)
    );

endmodule

/* src/tlb_lookup.sv */
`timescale 1ns/10ps

module tlb_lookup #(
    parameter int tlb_num
) (
    // entries as of the last clock edge
    input  tlb_pkg::tlb_entry_t [tlb_num-1:0] entries,
    // request of this port
    input  tlb_pkg::tlb_search_t              req,
    // result of this port
    output logic                              found,
    output logic [idx_w-1:0]                  index,
    output tlb_pkg::tlb_page_t                page
);

    // index width, kept in step with the store
    localparam int idx_w = (tlb_num > 1) ? $clog2(tlb_num) : 1;

    ////////////////////////////////////////
    // associative compare
    ////////////////////////////////////////

    // one bit per entry
    logic [tlb_num-1:0] hit;

    // vpn2 compare for all entries at once
    logic [tlb_num-1:0] vpn2_eq;

    // asid compare, bypassed by the global bit
    logic [tlb_num-1:0] asid_ok;

    for (genvar i = 0; i < tlb_num; i++) begin : g_cmp
        assign vpn2_eq[i] = entries[i].vpn2 == req.vpn2;
        assign asid_ok[i] = (entries[i].asid == req.asid) || entries[i].g;
        assign hit[i]     = vpn2_eq[i] && asid_ok[i];
    end

    // any entry at all
    assign found = |hit;

    ////////////////////////////////////////
    // hit index
    ////////////////////////////////////////

    // and-or over entry numbers
    // no priority logic, entries are kept unique by software
    // zero when nothing hits
    always_comb begin
        index = '0;
        for (int i = 0; i < tlb_num; i++) begin
            index = index | (idx_w'(i) & {idx_w{hit[i]}});
        end
    end

    ////////////////////////////////////////
    // page selection
    ////////////////////////////////////////

    // hit entry merged by and-or
    // all zero on a miss, so page falls to zero as well
    tlb_pkg::tlb_entry_t hit_entry;

    always_comb begin
        hit_entry = '0;
        for (int i = 0; i < tlb_num; i++) begin
            hit_entry = hit_entry | (entries[i] & {$bits(tlb_pkg::tlb_entry_t){hit[i]}});
        end
    end

    // even or odd half of the pair
    // picked by bit 12 of the address
    tlb_pkg::tlb_page_t even_page;
    tlb_pkg::tlb_page_t odd_page;

    assign even_page = hit_entry.page0;
    assign odd_page  = hit_entry.page1;

    // same and-or style as the merge above
    assign page = (even_page & {$bits(tlb_pkg::tlb_page_t){~req.odd_page}})
                | (odd_page  & {$bits(tlb_pkg::tlb_page_t){ req.odd_page}});

endmodule

/* src/tlb_entry_store.sv */
`timescale 1ns/10ps

module tlb_entry_store #(
    parameter int tlb_num
) (
    input  logic                                  clk,
    input  logic                                  we,
    // write port
    input  logic                                  w_valid,
    input  logic [idx_w-1:0]                      w_index,
    input  tlb_pkg::tlb_entry_t                   w_entry,
    // read port
    input  logic [idx_w-1:0]                      r_index,
    output tlb_pkg::tlb_entry_t                   r_entry,
    // whole array, seen by both search ports
    output tlb_pkg::tlb_entry_t [tlb_num-1:0]     entries
);

    // index width, at least one bit for a single entry
    localparam int idx_w = (tlb_num > 1) ? $clog2(tlb_num) : 1;

    ////////////////////////////////////////
    // entry registers
    ////////////////////////////////////////

    tlb_pkg::tlb_entry_t [tlb_num-1:0] entries_q;

    // index inside the array
    // only matters when tlb_num is not a power of two
    logic w_in_range;
    logic r_in_range;

    assign w_in_range = int'(w_index) < tlb_num;
    assign r_in_range = int'(r_index) < tlb_num;

    // reset leaves every entry zero
    // so vpn2 0 with asid 0 is the only thing that hits afterwards
    always_ff @(posedge clk or posedge we) begin
        if (we) begin
            entries_q <= '0;
        end else if (w_valid && w_in_range) begin
            // whole entry replaced in one edge
            entries_q[w_index] <= w_entry;
        end
    end

    ////////////////////////////////////////
    // outputs
    ////////////////////////////////////////

    // lookups see the state of the last edge
    assign entries = entries_q;

    // combinational read
    // an index past the last entry reads as zero
    always_comb begin
        r_entry = '0;
        if (r_in_range) begin
            r_entry = entries_q[r_index];
        end
    end

endmodule

/* src/tlb_pkg.sv */
package tlb_pkg;

    ////////////////////////////////////////
    // field widths
    ////////////////////////////////////////

    // virtual page pair number
    // one entry covers an even and an odd page
    typedef logic [18:0] vpn2_t;

    // address space id, compared unless g is set
    typedef logic [7:0] asid_t;

    // physical frame number of one page
    typedef logic [19:0] pfn_t;

    // cache attribute, coded as in the cp0 entrylo c field
    typedef logic [2:0] cattr_t;

    ////////////////////////////////////////
    // entry layout
    ////////////////////////////////////////

    // one physical page, 25 bits
    typedef struct packed {
        pfn_t   pfn;
        cattr_t c;
        // page may be written
        logic   d;
        // page mapping present
        logic   v;
    } tlb_page_t;

    // one full entry, 78 bits
    // page0 serves the even page, page1 the odd one
    typedef struct packed {
        vpn2_t     vpn2;
        asid_t     asid;
        // global, matches any asid
        logic      g;
        tlb_page_t page0;
        tlb_page_t page1;
    } tlb_entry_t;

    ////////////////////////////////////////
    // search request
    ////////////////////////////////////////

    // one lookup, 28 bits
    // odd_page is bit 12 of the virtual address
    typedef struct packed {
        vpn2_t vpn2;
        logic  odd_page;
        asid_t asid;
    } tlb_search_t;

    // entry count when the top level is left alone
    localparam int TLBNUM_DEFAULT = 16;

endpackage
